/* dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Cache geometry
`define DCACHE_WAYS 2

// 64 lines per way
`define DCACHE_LINE_W 6

// Word select within a line
`define DCACHE_WORD_W 2
`define DCACHE_WORDS 4

// Tag bits left above the line index and word select
`define DCACHE_TAG_W (32 - 2 - `DCACHE_WORD_W - `DCACHE_LINE_W)

`endif

/* dcache_pkg.sv */
`include "dcache_params.svh"

package dcache_pkg;

    // Field view of a byte address
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]  tag;
        logic [`DCACHE_LINE_W-1:0] line;
        logic [`DCACHE_WORD_W-1:0] word;
        logic [1:0]                offset;
    } addr_fields_t;

    // One address word, seen flat or split into its fields
    typedef union packed {
        logic [31:0]  flat;
        addr_fields_t fields;
    } dcache_addr_t;

    // One way of one tag line
    typedef struct packed {
        logic                     valid;
        logic [`DCACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    // Kind of request held in stage 1
    typedef enum logic {
        READ,
        WRITE
    } req_kind_t;

endpackage

/* dcache_ifs.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

//////////////////////////////////////////////////////////////////////
// Tag lookup between request control and the tag bank

interface tag_lookup_if;
    logic                      lookup_en;
    logic [`DCACHE_LINE_W-1:0] lookup_line;
    logic [`DCACHE_TAG_W-1:0]  cmp_tag;
    logic                      fill_write;
    logic [`DCACHE_LINE_W-1:0] fill_line;
    logic                      hit;
    logic [`DCACHE_WAYS-1:0]   hit_way;
    logic [`DCACHE_WAYS-1:0]   repl_way;
    logic                      busy;

    modport ctrl (
        output lookup_en, lookup_line, cmp_tag, fill_write, fill_line,
        input  hit, hit_way, repl_way, busy
    );

    modport bank (
        input  lookup_en, lookup_line, cmp_tag, fill_write, fill_line,
        output hit, hit_way, repl_way, busy
    );
endinterface

//////////////////////////////////////////////////////////////////////
// Data bank access, read port for lookups and write port for hits and fills

interface data_bank_if;
    logic                                     rd_en;
    logic [`DCACHE_LINE_W+`DCACHE_WORD_W-1:0] rd_addr;
    logic                                     wr_en;
    logic [`DCACHE_WAYS-1:0]                  wr_way;
    logic [`DCACHE_LINE_W+`DCACHE_WORD_W-1:0] wr_addr;
    logic [3:0]                               wr_be;
    logic [31:0]                              wr_data;
    logic [31:0]                              rd_data;

    modport ctrl (
        output rd_en, rd_addr, wr_en, wr_way, wr_addr, wr_be, wr_data,
        input  rd_data
    );

    modport bank (
        input  rd_en, rd_addr, wr_en, wr_way, wr_addr, wr_be, wr_data,
        output rd_data
    );
endinterface

/* dcache_tag_bank.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tag_bank import dcache_pkg::*; (
    input logic        clk,
    input logic        rst,
    tag_lookup_if.bank tl,
    input logic        mem_inv,
    input logic [31:0] mem_inv_addr
);

    localparam int LINES = 1 << `DCACHE_LINE_W;

    tag_entry_t [`DCACHE_WAYS-1:0] tag_mem [LINES];

    logic                          sweeping;
    logic                          sweep_done;
    logic [`DCACHE_LINE_W-1:0]     sweep_line;
    dcache_addr_t                  inv_addr;
    logic                          snoop_valid;
    logic [`DCACHE_LINE_W-1:0]     snoop_line_r;
    logic [`DCACHE_TAG_W-1:0]      snoop_tag_r;
    logic [`DCACHE_WAYS-1:0]       snoop_hit;
    logic                          snoop_write;
    logic [`DCACHE_WAYS-1:0]       hit_way;
    logic [`DCACHE_WAYS-1:0]       repl_way;
    logic                          a_en;
    logic [`DCACHE_WAYS-1:0]       a_wbe;
    logic [`DCACHE_LINE_W-1:0]     a_addr;
    tag_entry_t                    a_wdata;
    tag_entry_t [`DCACHE_WAYS-1:0] a_rdata;
    logic                          b_en;
    logic [`DCACHE_LINE_W-1:0]     b_addr;
    tag_entry_t [`DCACHE_WAYS-1:0] b_rdata;

    //////////////////////////////////////////////////////////////////////
    // Reset sweep, clears one line per cycle on port B
    assign sweeping = ~sweep_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_done <= 1'b0;
            sweep_line <= '0;
        end else if (sweeping) begin
            {sweep_done, sweep_line} <= {1'b0, sweep_line} + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Snoop path
    // Tags are read on port B in the snoop cycle and compared one cycle later
    assign inv_addr.flat = mem_inv_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_valid <= 1'b0;
        end else begin
            snoop_valid <= mem_inv & ~sweeping;
        end
    end

    always_ff @(posedge clk) begin
        snoop_line_r <= inv_addr.fields.line;
        snoop_tag_r  <= inv_addr.fields.tag;
    end

    assign snoop_write = snoop_valid & |snoop_hit;

    // One-hot replacement cycler
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_way <= `DCACHE_WAYS'(1);
        end else if (tl.lookup_en) begin
            repl_way <= {repl_way[`DCACHE_WAYS-2:0], repl_way[`DCACHE_WAYS-1]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Port A arbitration
    // Snoop writes win, then fills, then lookups
    always_comb begin
        a_addr  = tl.lookup_line;
        a_wbe   = '0;
        a_wdata = '{valid: 1'b1, tag: tl.cmp_tag};
        if (snoop_write) begin
            a_addr  = snoop_line_r;
            a_wbe   = snoop_hit;
            a_wdata = '0;
        end else if (tl.fill_write) begin
            a_addr = tl.fill_line;
            a_wbe  = repl_way;
        end
    end

    assign a_en   = snoop_write | tl.fill_write | tl.lookup_en;
    assign b_en   = mem_inv | sweeping;
    assign b_addr = sweeping ? sweep_line : inv_addr.fields.line;

    always_ff @(posedge clk) begin
        if (a_en) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                if (a_wbe[w]) begin
                    tag_mem[a_addr][w] <= a_wdata;
                end
            end
            a_rdata <= tag_mem[a_addr];
        end
        if (b_en) begin
            if (sweeping) begin
                tag_mem[b_addr] <= '0;
            end
            b_rdata <= tag_mem[b_addr];
        end
    end

    // Tag compare for lookups and snoops
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_way[w]   = a_rdata[w].valid & (a_rdata[w].tag == tl.cmp_tag);
            snoop_hit[w] = b_rdata[w].valid & (b_rdata[w].tag == snoop_tag_r);
        end
    end

    assign tl.hit      = |hit_way;
    assign tl.hit_way  = hit_way;
    assign tl.repl_way = repl_way;
    assign tl.busy     = sweeping | snoop_write;

endmodule

/* dcache_data_bank.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_data_bank (
    input logic                    clk,
    data_bank_if.bank              db,
    input logic [`DCACHE_WAYS-1:0] hit_way
);

    localparam int DEPTH = `DCACHE_WORDS << `DCACHE_LINE_W;

    // One 32-bit column group per way
    logic [`DCACHE_WAYS-1:0][31:0] data_mem [DEPTH];
    logic [`DCACHE_WAYS-1:0][31:0] rd_q;
    logic [31:0]                   rd_sel;
    logic                          same_addr;

    assign same_addr = db.wr_en & (db.wr_addr == db.rd_addr);

    //////////////////////////////////////////////////////////////////////
    // Byte-enabled write, synchronous read
    // A read of the word being written sees the new bytes
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (db.wr_en & db.wr_way[w] & db.wr_be[b]) begin
                    data_mem[db.wr_addr][w][b*8 +: 8] <= db.wr_data[b*8 +: 8];
                end
                if (db.rd_en) begin
                    if (same_addr & db.wr_way[w] & db.wr_be[b]) begin
                        rd_q[w][b*8 +: 8] <= db.wr_data[b*8 +: 8];
                    end else begin
                        rd_q[w][b*8 +: 8] <= data_mem[db.rd_addr][w][b*8 +: 8];
                    end
                end
            end
        end
    end

    // One-hot select of the hit way
    always_comb begin
        rd_sel = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            rd_sel = rd_sel | ({32{hit_way[w]}} & rd_q[w]);
        end
    end

    assign db.rd_data = rd_sel;

endmodule

/* dcache_request_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_request_ctrl import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // Load/store side
    input  logic        new_request,
    input  logic [31:0] addr,
    input  logic        we,
    input  logic [3:0]  be,
    input  logic [31:0] data_in,
    input  logic        uncacheable,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] data_out,
    // Memory side
    output logic        mem_request,
    output logic        mem_rnw,
    output logic [29:0] mem_addr,
    output logic [4:0]  mem_rlen,
    output logic [3:0]  mem_wbe,
    output logic [31:0] mem_wdata,
    input  logic        mem_ack,
    input  logic        mem_rvalid,
    input  logic [31:0] mem_rdata,
    input  logic        mem_inv,
    input  logic [31:0] mem_inv_addr,
    tag_lookup_if.ctrl  tl,
    data_bank_if.ctrl   db
);

    dcache_addr_t              stage0_addr;
    dcache_addr_t              stage1_addr;
    logic [31:0]               stage1_wdata;
    logic [3:0]                stage1_be;
    logic                      stage1_uc;
    req_kind_t                 stage1_kind;
    logic                      stage1_valid;
    logic                      stage1_done;
    logic                      accept;
    logic                      advance_r;
    logic                      is_read;
    logic                      hit_now;
    logic                      hit_write;
    logic                      request_sent;
    logic [`DCACHE_WORD_W-1:0] word_cnt;
    logic                      last_word;
    logic                      correct_word;
    logic                      inv_same_line;
    logic                      fill_r;
    logic                      fill_cancel;
    logic                      fill_drop;
    logic                      fill_data_en;

    //////////////////////////////////////////////////////////////////////
    // Stage 0 to stage 1
    assign stage0_addr.flat = addr;
    assign accept = new_request & ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_valid <= 1'b0;
            stage1_kind  <= READ;
            advance_r    <= 1'b0;
        end else begin
            advance_r <= accept;
            if (accept) begin
                stage1_valid <= 1'b1;
                stage1_kind  <= we ? WRITE : READ;
            end else if (stage1_done) begin
                stage1_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage1_addr  <= stage0_addr;
            stage1_wdata <= data_in;
            stage1_be    <= be;
            stage1_uc    <= uncacheable;
        end
    end

    // Lookup result is valid only in the cycle after acceptance
    assign is_read   = stage1_kind == READ;
    assign hit_now   = advance_r & tl.hit & ~stage1_uc;
    assign hit_write = hit_now & ~is_read;

    //////////////////////////////////////////////////////////////////////
    // Memory request and fill tracking
    always_ff @(posedge clk) begin
        if (rst | stage1_done) begin
            request_sent <= 1'b0;
            word_cnt     <= '0;
        end else begin
            word_cnt <= word_cnt + `DCACHE_WORD_W'(mem_rvalid);
            if (mem_ack) begin
                request_sent <= 1'b1;
            end
        end
    end

    assign last_word    = mem_rvalid & (stage1_uc | word_cnt == `DCACHE_WORD_W'(`DCACHE_WORDS-1));
    assign correct_word = mem_rvalid & (stage1_uc | word_cnt == stage1_addr.fields.word);

    // Tag write follows the ack by one cycle
    // A same-line snoop or a busy tag port cancels it and the rest of the fill
    assign inv_same_line = mem_inv &
        (mem_inv_addr[31:2+`DCACHE_WORD_W] == stage1_addr.flat[31:2+`DCACHE_WORD_W]);
    assign fill_cancel = fill_r & (inv_same_line | tl.busy);

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_r <= 1'b0;
        end else begin
            fill_r <= stage1_valid & mem_ack & is_read & ~stage1_uc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst | stage1_done) begin
            fill_drop <= 1'b0;
        end else if (fill_cancel) begin
            fill_drop <= 1'b1;
        end
    end

    assign fill_data_en = mem_rvalid & is_read & ~stage1_uc & ~fill_drop & ~fill_cancel;

    always_comb begin
        if (!stage1_valid) begin
            stage1_done = 1'b0;
        end else if (stage1_kind == WRITE) begin
            stage1_done = mem_ack;
        end else if (advance_r) begin
            stage1_done = hit_now;
        end else begin
            stage1_done = last_word;
        end
    end

    assign ready = ~tl.busy & (~stage1_valid | stage1_done);

    //////////////////////////////////////////////////////////////////////
    // Outputs
    assign mem_request = stage1_valid & ~request_sent &
        (stage1_kind == WRITE | ~advance_r);
    assign mem_rnw   = is_read;
    assign mem_addr  = (is_read & ~stage1_uc) ?
        {stage1_addr.flat[31:2+`DCACHE_WORD_W], {`DCACHE_WORD_W{1'b0}}} :
        stage1_addr.flat[31:2];
    assign mem_rlen  = (is_read & ~stage1_uc) ? 5'(`DCACHE_WORDS-1) : 5'd0;
    assign mem_wbe   = stage1_be;
    assign mem_wdata = stage1_wdata;

    assign data_valid = stage1_valid & is_read & (advance_r ? hit_now : correct_word);
    assign data_out   = advance_r ? db.rd_data : mem_rdata;

    assign tl.lookup_en   = accept;
    assign tl.lookup_line = stage0_addr.fields.line;
    assign tl.cmp_tag     = stage1_addr.fields.tag;
    assign tl.fill_write  = fill_r & ~fill_cancel;
    assign tl.fill_line   = stage1_addr.fields.line;

    // Writes land in the hit way, fills in the replacement way
    assign db.rd_en   = accept;
    assign db.rd_addr = {stage0_addr.fields.line, stage0_addr.fields.word};
    assign db.wr_en   = hit_write | fill_data_en;
    assign db.wr_way  = hit_write ? tl.hit_way : tl.repl_way;
    assign db.wr_addr = {stage1_addr.fields.line, hit_write ? stage1_addr.fields.word : word_cnt};
    assign db.wr_be   = hit_write ? stage1_be : 4'hf;
    assign db.wr_data = hit_write ? stage1_wdata : mem_rdata;

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic        clk,
    input  logic        rst,
    // Load/store side
    input  logic        new_request,
    input  logic [31:0] addr,
    input  logic        we,
    input  logic [3:0]  be,
    input  logic [31:0] data_in,
    input  logic        uncacheable,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] data_out,
    // Memory side
    output logic        mem_request,
    output logic        mem_rnw,
    output logic [29:0] mem_addr,
    output logic [4:0]  mem_rlen,
    output logic [3:0]  mem_wbe,
    output logic [31:0] mem_wdata,
    input  logic        mem_ack,
    input  logic        mem_rvalid,
    input  logic [31:0] mem_rdata,
    input  logic        mem_inv,
    input  logic [31:0] mem_inv_addr
);

    tag_lookup_if tl_if ();
    data_bank_if  db_if ();

    dcache_request_ctrl ctrl_i (
        .tl(tl_if.ctrl),
        .db(db_if.ctrl),
        .*
    );

    dcache_tag_bank tag_bank_i (
        .clk(clk),
        .rst(rst),
        .tl(tl_if.bank),
        .mem_inv(mem_inv),
        .mem_inv_addr(mem_inv_addr)
    );

    dcache_data_bank data_bank_i (
        .clk(clk),
        .db(db_if.bank),
        .hit_way(tl_if.hit_way)
    );

endmodule

/* dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int TIMEOUT   = 200;
    localparam int MEM_WORDS = 4096;
    localparam int ACK_DELAY = 2;

    logic        clk;
    logic        rst;
    logic        new_request;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] data_in;
    logic        uncacheable;
    logic        ready;
    logic        data_valid;
    logic [31:0] data_out;
    logic        mem_request;
    logic        mem_rnw;
    logic [29:0] mem_addr;
    logic [4:0]  mem_rlen;
    logic [3:0]  mem_wbe;
    logic [31:0] mem_wdata;
    logic        mem_ack;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic        mem_inv;
    logic [31:0] mem_inv_addr;

    // Backing memory word-addressed by address bits 13:2
    logic [31:0] mem_words [MEM_WORDS];

    dcache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Error reporting and compare tasks

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("[FAIL] %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_be(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("[FAIL] %s: byte enables expected %b, got %b",
                name, exp, act));
        end
    endtask

    task automatic check_mem_req(input string name, input logic [29:0] exp_addr,
                                 input logic exp_rnw, input logic [4:0] exp_rlen);
        if (mem_addr !== exp_addr) begin
            stop_with_error($sformatf("[FAIL] %s: mem_addr expected %h, got %h",
                name, exp_addr, mem_addr));
        end
        if (mem_rnw !== exp_rnw) begin
            stop_with_error($sformatf("[FAIL] %s: mem_rnw expected %b, got %b",
                name, exp_rnw, mem_rnw));
        end
        if (mem_rlen !== exp_rlen) begin
            stop_with_error($sformatf("[FAIL] %s: mem_rlen expected %0d, got %0d",
                name, exp_rlen, mem_rlen));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers and memory model

    function automatic logic [31:0] make_addr(input logic [31:0] tag, input logic [31:0] line,
                                              input logic [31:0] word);
        dcache_addr_t a;
        a.fields.tag    = tag[`DCACHE_TAG_W-1:0];
        a.fields.line   = line[`DCACHE_LINE_W-1:0];
        a.fields.word   = word[`DCACHE_WORD_W-1:0];
        a.fields.offset = 2'b00;
        return a.flat;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] mask);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[b*8 +: 8] = mask[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ready !== 1'b1) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_error($sformatf("%s: ready never went high", name));
            end
            @(negedge clk);
        end
    endtask

    // Holds new_request until the cache takes it and returns just after the accepting edge
    task automatic issue_request(input string name, input logic [31:0] a, input logic wr,
                                 input logic [3:0] b, input logic [31:0] d, input logic uc);
        int cycles;
        cycles = 0;
        @(posedge clk);
        new_request <= 1'b1;
        addr        <= a;
        we          <= wr;
        be          <= b;
        data_in     <= d;
        uncacheable <= uc;
        @(negedge clk);
        while (ready !== 1'b1) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_error($sformatf("%s: request was never accepted", name));
            end
            @(negedge clk);
        end
        @(posedge clk);
        new_request <= 1'b0;
    endtask

    task automatic wait_mem_request(input string name);
        int cycles;
        cycles = 0;
        while (mem_request !== 1'b1) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_error($sformatf("%s: no memory request was issued", name));
            end
            @(negedge clk);
        end
    endtask

    // Returns at the falling edge of the ack cycle while mem_ack is still high
    task automatic hold_until_ack(input string name);
        for (int d = 0; d < ACK_DELAY; d++) begin
            @(negedge clk);
            if (mem_request !== 1'b1) begin
                stop_with_error($sformatf("%s: mem_request dropped before mem_ack", name));
            end
        end
        @(posedge clk);
        mem_ack <= 1'b1;
        @(negedge clk);
    endtask

    // Burst from the given word address with data_valid expected only on word want
    task automatic serve_read(input string name, input logic [29:0] exp_addr,
                              input logic [4:0] rlen, input int want);
        wait_mem_request(name);
        check_mem_req(name, exp_addr, 1'b1, rlen);
        hold_until_ack(name);
        for (int i = 0; i <= rlen; i++) begin
            @(posedge clk);
            mem_ack    <= 1'b0;
            mem_rvalid <= 1'b1;
            mem_rdata  <= mem_words[exp_addr[11:0] + i];
            @(negedge clk);
            if (data_valid !== (i == want)) begin
                stop_with_error($sformatf(
                    "[FAIL] %s: data_valid at burst word %0d expected %b, got %b",
                    name, i, i == want, data_valid));
            end
            if (data_valid) begin
                check_word(name, mem_words[exp_addr[11:0] + i], data_out);
            end
        end
        @(posedge clk);
        mem_rvalid <= 1'b0;
        mem_rdata  <= '0;
    endtask

    task automatic serve_write(input string name, input logic [31:0] a,
                               input logic [3:0] b, input logic [31:0] d);
        wait_mem_request(name);
        check_mem_req(name, a[31:2], 1'b0, 5'd0);
        check_be(name, b, mem_wbe);
        check_word(name, d, mem_wdata);
        hold_until_ack(name);
        if (ready !== 1'b1) begin
            stop_with_error($sformatf("%s: write did not complete on mem_ack", name));
        end
        mem_words[a[13:2]] = merge_bytes(mem_words[a[13:2]], d, b);
        @(posedge clk);
        mem_ack <= 1'b0;
    endtask

    task automatic read_and_check(input string name, input logic [31:0] a,
                                  input logic uc, input logic expect_hit);
        logic [29:0] req_addr;
        int          want;
        req_addr = uc ? a[31:2] : {a[31:4], 2'b00};
        want     = uc ? 0 : int'(a[3:2]);
        issue_request(name, a, 1'b0, 4'hf, 32'h0, uc);
        @(negedge clk);
        if (expect_hit) begin
            if (data_valid !== 1'b1) begin
                stop_with_error($sformatf("%s: no data_valid one cycle after acceptance", name));
            end
            check_word(name, mem_words[a[13:2]], data_out);
            @(negedge clk);
            if (mem_request !== 1'b0) begin
                stop_with_error($sformatf("%s: read hit issued a memory request", name));
            end
        end else begin
            if (data_valid !== 1'b0) begin
                stop_with_error($sformatf("%s: data_valid on a miss before the fill", name));
            end
            serve_read(name, req_addr, uc ? 5'd0 : 5'd3, want);
        end
    endtask

    task automatic write_and_check(input string name, input logic [31:0] a,
                                   input logic [3:0] b, input logic [31:0] d);
        issue_request(name, a, 1'b1, b, d, 1'b0);
        @(negedge clk);
        serve_write(name, a, b, d);
    endtask

    task automatic pulse_snoop(input logic [31:0] a);
        @(posedge clk);
        mem_inv      <= 1'b1;
        mem_inv_addr <= a;
        @(posedge clk);
        mem_inv <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic reset_sweep_and_miss();
        wait_ready("reset sweep");
        read_and_check("read miss after reset", make_addr(0, 1, 2), 1'b0, 1'b0);
    endtask

    task automatic read_hit_same_line();
        read_and_check("read hit word 0", make_addr(0, 1, 0), 1'b0, 1'b1);
        read_and_check("read hit word 1", make_addr(0, 1, 1), 1'b0, 1'b1);
        read_and_check("read hit word 3", make_addr(0, 1, 3), 1'b0, 1'b1);
    endtask

    task automatic write_through_merge();
        write_and_check("partial write", make_addr(0, 1, 1), 4'b0101, $urandom());
        read_and_check("read back merged word", make_addr(0, 1, 1), 1'b0, 1'b1);
        write_and_check("full write", make_addr(0, 1, 3), 4'b1111, $urandom());
        read_and_check("read back full word", make_addr(0, 1, 3), 1'b0, 1'b1);
    endtask

    task automatic uncacheable_read();
        read_and_check("uncacheable read", make_addr(1, 5, 3), 1'b1, 1'b0);
        read_and_check("cacheable read after uncacheable", make_addr(1, 5, 3), 1'b0, 1'b0);
        read_and_check("hit after fill", make_addr(1, 5, 0), 1'b0, 1'b1);
    endtask

    task automatic snoop_invalidation();
        read_and_check("fill before snoop", make_addr(3, 9, 2), 1'b0, 1'b0);
        read_and_check("hit before snoop", make_addr(3, 9, 2), 1'b0, 1'b1);
        pulse_snoop(make_addr(3, 9, 0));
        read_and_check("refetch after snoop", make_addr(3, 9, 2), 1'b0, 1'b0);
        // Same line index with another tag
        pulse_snoop(make_addr(7, 9, 0));
        read_and_check("hit after unrelated snoop", make_addr(3, 9, 1), 1'b0, 1'b1);
    endtask

    initial begin
        new_request  = 1'b0;
        addr         = '0;
        we           = 1'b0;
        be           = '0;
        data_in      = '0;
        uncacheable  = 1'b0;
        mem_ack      = 1'b0;
        mem_rvalid   = 1'b0;
        mem_rdata    = '0;
        mem_inv      = 1'b0;
        mem_inv_addr = '0;
        rst          = 1'b1;
        void'($urandom(32'hb168_7245));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = $urandom();
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        reset_sweep_and_miss();
        read_hit_same_line();
        write_through_merge();
        uncacheable_read();
        snoop_invalidation();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* dcache.f */
+incdir+.
dcache_pkg.sv
dcache_ifs.sv
dcache_tag_bank.sv
dcache_data_bank.sv
dcache_request_ctrl.sv
dcache_top.sv
dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_ifs.sv
      - dcache_tag_bank.sv
      - dcache_data_bank.sv
      - dcache_request_ctrl.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dcache_tb.sv
